// File: dv/dma_props.sv
`timescale 1ns/1ps

module dma_props
    import dma_xfer_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input mem_req_t mem_req,
    input mem_rsp_t mem_rsp,
    input dev_rsp_t snd_rsp,
    input dev_rsp_t flp_rsp
);

    int fail_count = 0;

    // ------------------------------------------------------------
    // memory bus
    // ------------------------------------------------------------
    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req.read && mem_req.write))
        else begin
            $error("memory read and write high together");
            fail_count++;
        end

    a_hold_req: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req.read || mem_req.write) && mem_rsp.waitrequest |=> $stable(mem_req))
        else begin
            $error("memory request changed under waitrequest");
            fail_count++;
        end

    // device pulses
    a_snd_ack:  assert property (@(posedge clk) disable iff (!rst_n)
        snd_rsp.ack |=> !snd_rsp.ack)
        else begin
            $error("sound ack longer than one cycle");
            fail_count++;
        end
    a_flp_ack:  assert property (@(posedge clk) disable iff (!rst_n)
        flp_rsp.ack |=> !flp_rsp.ack)
        else begin
            $error("floppy ack longer than one cycle");
            fail_count++;
        end
    a_snd_term: assert property (@(posedge clk) disable iff (!rst_n)
        snd_rsp.terminal |=> !snd_rsp.terminal)
        else begin
            $error("sound terminal too long");
            fail_count++;
        end
    a_flp_term: assert property (@(posedge clk) disable iff (!rst_n)
        flp_rsp.terminal |=> !flp_rsp.terminal)
        else begin
            $error("floppy terminal too long");
            fail_count++;
        end

endmodule

// File: dv/dma_tb.sv
`timescale 1ns/1ps

module dma_tb
    import dma_reg_pkg::*, dma_xfer_pkg::*;
;

    localparam int TOTAL_BEATS     = 39;  // sum of the transfer lengths below
    localparam int CYCLES_PER_BEAT = 40;

    logic     clk;
    logic     rst_n;
    io_bus_t  io;
    byte_t    io_readdata;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    dev_req_t snd_req, flp_req;
    dev_rsp_t snd_rsp, flp_rsp;

    integer   seed = 32'hf1951495;
    int       value_errs = 0;
    int       other_errs = 0;
    int       snd_left = 0;
    int       flp_left = 0;
    bit       snd_term = 0;
    bit       flp_term = 0;
    dev_rsp_t flp_term_rsp;
    mem_req_t bus_log[$];
    dev_rsp_t flp_log[$];
    dev_rsp_t snd_log[$];

    dma_top i_dut (.*);

    bind dma_top dma_props i_props (.clk(clk), .rst_n(rst_n), .mem_req(mem_req),
        .mem_rsp(mem_rsp), .snd_rsp(snd_rsp), .flp_rsp(flp_rsp));

    always #2 clk = !clk;

    // ------------------------------------------------------------
    // memory and device models, bus monitor
    // ------------------------------------------------------------
    always @(posedge clk) begin
        mem_rsp.waitrequest   <= $random(seed) & 1;
        mem_rsp.readdatavalid <= mem_req.read && !mem_rsp.waitrequest;
        mem_rsp.readdata      <= mem_req.address[7:0];  // data is the low address byte
        if (rst_n && (mem_req.read || mem_req.write) && !mem_rsp.waitrequest)
            bus_log.push_back(mem_req);
        if (snd_rsp.ack) begin
            snd_log.push_back(snd_rsp);
            snd_left = snd_left - 1;
            if (snd_left == 0)
                snd_req.req <= 1'b0;   // drop before an auto-init restart
            snd_req.writedata <= snd_req.writedata + 8'h11;
        end
        if (flp_rsp.ack) begin
            flp_log.push_back(flp_rsp);
            flp_left = flp_left - 1;
            if (flp_left == 0)
                flp_req.req <= 1'b0;
        end
        if (snd_rsp.terminal)
            snd_term = 1'b1;
        if (flp_rsp.terminal) begin
            flp_term     = 1'b1;
            flp_term_rsp = flp_rsp;
        end
    end

    task automatic check_byte(string name, byte_t exp, byte_t act);
        if (act !== exp) begin
            value_errs++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(string name, mem_req_t exp, mem_req_t act);
        if (act.address !== exp.address) begin
            value_errs++;
            $display("FAIL %s: expected %h, actual %h", name, exp.address, act.address);
        end
    endtask

    task automatic check_rsp(string name, dev_rsp_t exp, dev_rsp_t act);
        if (act !== exp) begin
            value_errs++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic io_write(logic [3:0] addr, byte_t data, logic page);
        @(posedge clk);
        io <= '{address: addr, read: 1'b0, write: 1'b1, writedata: data,
                slave_cs: !page, page_cs: page};
        @(posedge clk);
        io <= '0;
    endtask

    task automatic io_read(logic [3:0] addr, logic page, output byte_t data);
        @(posedge clk);
        io <= '{address: addr, read: 1'b1, write: 1'b0, writedata: 8'h00,
                slave_cs: !page, page_cs: page};
        @(posedge clk);
        io <= '0;
        @(negedge clk);
        data = io_readdata;
    endtask

    task automatic read_expect(string name, logic [3:0] addr, logic page, byte_t exp);
        byte_t d;
        io_read(addr, page, d);
        check_byte(name, exp, d);
    endtask

    task automatic program_channel(logic [3:0] areg, logic [3:0] creg, word_t a, word_t c);
        io_write(REG_CLEAR_PTR, 8'h00, 1'b0);
        io_write(areg, a[7:0], 1'b0);
        io_write(areg, a[15:8], 1'b0);
        io_write(creg, c[7:0], 1'b0);
        io_write(creg, c[15:8], 1'b0);
    endtask

    task automatic wait_terminal(bit floppy);
        int n;
        n = 0;
        while (!(floppy ? flp_term : snd_term) && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (n >= 2000) begin
            other_errs++;
            $display("no terminal pulse from channel %0d", floppy ? 2 : 1);
        end
    endtask

    task automatic test_reset_state();
        read_expect("reset mask", REG_ALL_MASK, 1'b0, 8'hff);
        read_expect("reset status", REG_STATUS_CMD, 1'b0, 8'h00);
    endtask

    task automatic test_register_access();
        program_channel(REG_ADDR_CH1, REG_COUNT_CH1, 16'h1234, 16'h5678);
        program_channel(REG_ADDR_CH2, REG_COUNT_CH2, 16'h9abc, 16'hdef0);
        io_write(REG_CLEAR_PTR, 8'h00, 1'b0);
        read_expect("ch1 addr lo", REG_ADDR_CH1, 1'b0, 8'h34);
        read_expect("ch1 addr hi", REG_ADDR_CH1, 1'b0, 8'h12);
        read_expect("ch1 count lo", REG_COUNT_CH1, 1'b0, 8'h78);
        read_expect("ch1 count hi", REG_COUNT_CH1, 1'b0, 8'h56);
        read_expect("ch2 addr lo", REG_ADDR_CH2, 1'b0, 8'hbc);
        read_expect("ch2 addr hi", REG_ADDR_CH2, 1'b0, 8'h9a);
        read_expect("ch2 count lo", REG_COUNT_CH2, 1'b0, 8'hf0);
        io_write(REG_CLEAR_PTR, 8'h00, 1'b0);   // pointer was left on the high byte
        read_expect("ch2 count after clear", REG_COUNT_CH2, 1'b0, 8'hf0);
        io_write(PAGE_CH1, 8'h31, 1'b1);
        io_write(PAGE_CH2, 8'h4c, 1'b1);
        io_write(4'd7, 8'ha5, 1'b1);
        read_expect("page ch1", PAGE_CH1, 1'b1, 8'h31);
        read_expect("page ch2", PAGE_CH2, 1'b1, 8'h4c);
        read_expect("scratch page", 4'd0, 1'b1, 8'ha5);
    endtask

    task automatic test_ch2_read();
        word_t    a;
        dev_rsp_t exp;
        a = 16'h10fe;
        program_channel(REG_ADDR_CH2, REG_COUNT_CH2, a, 16'd5);
        io_write(REG_MODE, 8'h4a, 1'b0);        // read, increment, single shot
        io_write(REG_SINGLE_MASK, 8'h02, 1'b0);
        bus_log.delete();
        flp_log.delete();
        flp_left = 6;
        flp_term = 0;
        @(posedge clk);
        flp_req.req <= 1'b1;
        wait_terminal(1'b1);
        if (bus_log.size() != 6 || flp_log.size() != 6) begin
            other_errs++;
            $display("ch2 read made %0d bus reads and %0d acks", bus_log.size(), flp_log.size());
        end
        foreach (bus_log[i]) begin
            check_addr("ch2 read addr", '{address: {8'h4c, a + 16'(i)}, default: '0}, bus_log[i]);
        end
        foreach (flp_log[i]) begin
            exp = '{ack: 1'b1, terminal: 1'b0, readdata: 8'(a + 16'(i))};
            check_rsp("ch2 device data", exp, flp_log[i]);
        end
        check_rsp("ch2 terminal", '{ack: 1'b0, terminal: 1'b1, readdata: 8'(a + 16'd5)},
            flp_term_rsp);
        read_expect("ch2 status", REG_STATUS_CMD, 1'b0, 8'h04);
        read_expect("status after read", REG_STATUS_CMD, 1'b0, 8'h00);
        read_expect("ch2 mask", REG_ALL_MASK, 1'b0, 8'hff);
    endtask

    task automatic test_ch1_write_auto();
        byte_t d0;
        d0 = $random(seed);
        program_channel(REG_ADDR_CH1, REG_COUNT_CH1, 16'h2003, 16'd4);
        io_write(REG_MODE, 8'h75, 1'b0);        // write, auto-init, decrement
        io_write(REG_SINGLE_MASK, 8'h01, 1'b0);
        bus_log.delete();
        snd_left = 5;
        snd_term = 0;
        @(posedge clk);
        snd_req.writedata <= d0;
        snd_req.req       <= 1'b1;
        wait_terminal(1'b0);
        if (bus_log.size() != 5) begin
            other_errs++;
            $display("ch1 write made %0d bus writes instead of 5", bus_log.size());
        end
        foreach (bus_log[i]) begin
            check_addr("ch1 write addr", '{address: {8'h31, 16'h2003 - 16'(i)}, default: '0},
                bus_log[i]);
            check_byte("ch1 write data", d0 + 8'(8'h11 * i), bus_log[i].writedata);
        end
        io_write(REG_CLEAR_PTR, 8'h00, 1'b0);
        read_expect("ch1 reload addr lo", REG_ADDR_CH1, 1'b0, 8'h03);
        read_expect("ch1 reload addr hi", REG_ADDR_CH1, 1'b0, 8'h20);
        read_expect("ch1 reload count lo", REG_COUNT_CH1, 1'b0, 8'h04);
        read_expect("ch1 reload count hi", REG_COUNT_CH1, 1'b0, 8'h00);
        read_expect("ch1 mask stays clear", REG_ALL_MASK, 1'b0, 8'hfd);
    endtask

    task automatic test_priority();
        int       n1;
        bit       seen2;
        dev_rsp_t exp;
        program_channel(REG_ADDR_CH1, REG_COUNT_CH1, 16'h0500, 16'd2);
        program_channel(REG_ADDR_CH2, REG_COUNT_CH2, 16'h0900, 16'd3);
        io_write(REG_MODE, 8'h49, 1'b0);
        io_write(REG_MODE, 8'h4a, 1'b0);
        io_write(REG_CLEAR_MASK, 8'h00, 1'b0);
        bus_log.delete();
        snd_log.delete();
        snd_left = 3;
        flp_left = 4;
        snd_term = 0;
        flp_term = 0;
        @(posedge clk);
        snd_req.req <= 1'b1;
        flp_req.req <= 1'b1;
        wait_terminal(1'b0);
        wait_terminal(1'b1);
        n1 = 0;
        seen2 = 0;
        foreach (bus_log[i]) begin
            if (bus_log[i].address[23:16] == 8'h4c) begin
                seen2 = 1;
            end else begin
                n1++;
                if (seen2) begin
                    other_errs++;
                    $display("channel 1 bus cycle came after channel 2 had started");
                end
            end
        end
        if (n1 != 3 || bus_log.size() != 7 || snd_log.size() != 3) begin
            other_errs++;
            $display("priority test made %0d ch1 and %0d total cycles, %0d sound acks",
                n1, bus_log.size(), snd_log.size());
        end
        foreach (snd_log[i]) begin
            exp = '{ack: 1'b1, terminal: 1'b0, readdata: 8'(16'h0500 + 16'(i))};
            check_rsp("ch1 device data", exp, snd_log[i]);
        end
    endtask

    task automatic test_master_reset();
        int n0;
        program_channel(REG_ADDR_CH2, REG_COUNT_CH2, 16'h0a00, 16'd20);
        io_write(REG_SINGLE_MASK, 8'h02, 1'b0);
        flp_log.delete();
        flp_left = 21;
        @(posedge clk);
        flp_req.req <= 1'b1;
        while (flp_log.size() < 3)
            @(negedge clk);
        io_write(REG_MASTER_RESET, 8'h00, 1'b0);
        n0 = bus_log.size();
        repeat (30) @(posedge clk);
        if (bus_log.size() > n0 + 1) begin     // one cycle may already be in flight
            other_errs++;
            $display("bus cycles went on after master reset");
        end
        flp_req.req <= 1'b0;
        read_expect("mask after master reset", REG_ALL_MASK, 1'b0, 8'hff);
    endtask

    initial begin
        repeat (TOTAL_BEATS * CYCLES_PER_BEAT + 1000) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Errors found");
        $finish;
    end

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        io      = '0;
        mem_rsp = '0;
        snd_req = '0;
        flp_req = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_register_access();
        test_ch2_read();
        test_ch1_write_auto();
        test_priority();
        test_master_reset();
        repeat (5) @(posedge clk);
        $display("value errors: %0d, other errors: %0d, assertion errors: %0d",
            value_errs, other_errs, i_dut.i_props.fail_count);
        if (value_errs == 0 && other_errs == 0 && i_dut.i_props.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: source/dma_bus_master.sv
`timescale 1ns/1ps

module dma_bus_master
    import dma_reg_pkg::*, dma_xfer_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ch1_issue_read,
    input  logic        ch1_issue_write,
    input  logic        ch2_issue_read,
    input  logic        ch2_issue_write,
    input  logic [23:0] ch1_address,
    input  logic [23:0] ch2_address,
    input  byte_t       ch1_data,
    input  byte_t       ch2_data,
    output mem_req_t    mem_req,
    input  mem_rsp_t    mem_rsp,
    output logic        ch1_done,
    output logic        ch2_done,
    output byte_t       readdata
);

    logic [23:0] addr_q;
    byte_t       data_q;
    logic        rd_q;
    logic        wr_q;
    logic        owner;     // set while channel 2 owns the cycle
    logic        rd_wait;   // read issued, data not back yet
    logic        issue2;
    logic        issue_any;
    logic        rd_done;
    logic        wr_done;

    assign issue2    = ch2_issue_read || ch2_issue_write;
    assign issue_any = issue2 || ch1_issue_read || ch1_issue_write;
    assign rd_done   = rd_wait && mem_rsp.readdatavalid;
    assign wr_done   = wr_q && !mem_rsp.waitrequest;
    assign ch1_done  = (rd_done || wr_done) && !owner;
    assign ch2_done  = (rd_done || wr_done) && owner;

    assign mem_req = '{address: addr_q, read: rd_q, write: wr_q, writedata: data_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q    <= 1'b0;
            wr_q    <= 1'b0;
            owner   <= 1'b0;
            rd_wait <= 1'b0;
        end else if (issue_any) begin
            rd_q    <= ch1_issue_read || ch2_issue_read;
            wr_q    <= ch1_issue_write || ch2_issue_write;
            rd_wait <= ch1_issue_read || ch2_issue_read;
            owner   <= issue2;
        end else begin
            if (!mem_rsp.waitrequest) begin     // held under back-pressure
                rd_q <= 1'b0;
                wr_q <= 1'b0;
            end
            if (rd_done)
                rd_wait <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_any) begin
            addr_q <= issue2 ? ch2_address : ch1_address;
            data_q <= issue2 ? ch2_data : ch1_data;
        end
        if (rd_done)
            readdata <= mem_rsp.readdata;
    end

endmodule

// File: source/dma_channel_fsm.sv
`timescale 1ns/1ps

module dma_channel_fsm
    import dma_reg_pkg::*, dma_xfer_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       grant,
    input  logic       resume,
    input  chan_mode_t mode,
    input  dev_req_t   dev,
    input  logic       beat_done,
    input  logic       count_zero,
    output logic       issue_read,
    output logic       issue_write,
    output logic       busy,
    output logic       update,
    output logic       tc,
    output logic       ack,
    output logic       terminal
);

    xfer_state_e state;
    xfer_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (grant)
                    state_nxt = PREPARE;
            end
            PREPARE: begin
                if (mode.transfer == XFER_READ || mode.transfer == XFER_WRITE)
                    state_nxt = BUS;
                else
                    state_nxt = VERIFY;     // verify and the illegal code
            end
            BUS: begin
                if (beat_done)
                    state_nxt = UPDATE;
            end
            VERIFY:  state_nxt = UPDATE;
            UPDATE:  state_nxt = tc ? IDLE : HOLD;
            HOLD: begin
                if (dev.req && resume)
                    state_nxt = PREPARE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            terminal <= 1'b0;
        end else begin
            state    <= clear ? IDLE : state_nxt;
            terminal <= tc;     // one cycle after the last ack
        end
    end

    // ------------------------------------------------------------
    // pulses toward the bus master, registers and device
    // ------------------------------------------------------------
    assign issue_read  = state == PREPARE && mode.transfer == XFER_READ;
    assign issue_write = state == PREPARE && mode.transfer == XFER_WRITE;
    assign busy        = state != IDLE && state != HOLD;
    assign update      = state == UPDATE;
    assign tc          = update && count_zero;
    assign ack         = update;

endmodule

// File: source/dma_channel_regs.sv
`timescale 1ns/1ps

module dma_channel_regs
    import dma_reg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  chan_wr_t   wr,
    input  chan_mode_t mode,
    input  logic       update,
    input  logic       tc,
    input  logic       clear,
    output word_t      cur_addr,
    output word_t      cur_count
);

    word_t base_addr;
    word_t base_count;

    function automatic word_t put_byte(word_t w, chan_wr_t s);
        return s.high_byte ? {s.data, w[7:0]} : {w[15:8], s.data};
    endfunction

    // a register write lands in base and current alike
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_addr <= '0;
            cur_addr  <= '0;
        end else if (wr.addr_we) begin
            base_addr <= put_byte(base_addr, wr);
            cur_addr  <= put_byte(base_addr, wr);
        end else if (!clear) begin  // master reset drops the beat
            if (tc && mode.auto_init)
                cur_addr <= base_addr;
            else if (update)
                cur_addr <= mode.decrement ? cur_addr - 16'd1 : cur_addr + 16'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_count <= '0;
            cur_count  <= '0;
        end else if (wr.count_we) begin
            base_count <= put_byte(base_count, wr);
            cur_count  <= put_byte(base_count, wr);
        end else if (!clear) begin
            if (tc && mode.auto_init)
                cur_count <= base_count;
            else if (update)
                cur_count <= cur_count - 16'd1;     // wraps to ffff after the last beat
        end
    end

endmodule

// File: source/dma_control_regs.sv
`timescale 1ns/1ps

module dma_control_regs
    import dma_reg_pkg::*, dma_xfer_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  io_bus_t    io,
    output byte_t      readback,
    output chan_wr_t   ch1_wr,
    output chan_wr_t   ch2_wr,
    input  word_t      ch1_addr,
    input  word_t      ch1_count,
    input  word_t      ch2_addr,
    input  word_t      ch2_count,
    output chan_mode_t ch1_mode,
    output chan_mode_t ch2_mode,
    output logic       ch1_grant,
    output logic       ch2_grant,
    output logic       ch1_resume,
    output logic       ch2_resume,
    output logic       clear,
    input  logic       snd_level,
    input  logic       flp_level,
    input  logic       ch1_tc,
    input  logic       ch2_tc
);

    logic       rd_last;
    logic       rd_stb;
    logic       wr_stb;
    logic       ptr;        // byte pointer, 0 selects the low byte
    logic       disabled;
    logic [3:0] mask;
    logic [3:0] sw_req;
    logic [3:0] pending;
    logic [3:0] term;
    logic [3:0] cmd_bit;
    logic [3:0] tc_bits;
    logic [3:0] auto_bits;
    logic       en1;
    logic       en2;
    dma_cmd_u   cmd;
    chan_mode_t new_mode;

    assign wr_stb    = io.write && io.slave_cs;
    assign rd_stb    = io.read && io.slave_cs && !rd_last;  // held read counts once
    assign clear     = wr_stb && io.address == REG_MASTER_RESET;
    assign cmd       = io.writedata;
    assign cmd_bit   = 4'b0001 << cmd.flag.channel;
    assign tc_bits   = {1'b0, ch2_tc, ch1_tc, 1'b0};
    assign auto_bits = {1'b0, ch2_mode.auto_init, ch1_mode.auto_init, 1'b0};
    assign new_mode  = '{cmd.mode.transfer, cmd.mode.auto_init, cmd.mode.decrement};

    assign ch1_wr = '{addr_we: wr_stb && io.address == REG_ADDR_CH1,
                      count_we: wr_stb && io.address == REG_COUNT_CH1,
                      high_byte: ptr, data: io.writedata};
    assign ch2_wr = '{addr_we: wr_stb && io.address == REG_ADDR_CH2,
                      count_we: wr_stb && io.address == REG_COUNT_CH2,
                      high_byte: ptr, data: io.writedata};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_last <= 1'b0;
            ptr     <= 1'b0;
        end else begin
            rd_last <= io.read && io.slave_cs;
            if (clear || (wr_stb && io.address == REG_CLEAR_PTR)) begin
                ptr <= 1'b0;
            end else if ((rd_stb || wr_stb) &&
                         io.address inside {[REG_ADDR_CH1:REG_COUNT_CH2]}) begin
                ptr <= !ptr;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ch1_mode <= '0;
            ch2_mode <= '0;
        end else if (wr_stb && io.address == REG_MODE) begin
            if (cmd.mode.channel == 2'd1)
                ch1_mode <= new_mode;
            if (cmd.mode.channel == 2'd2)
                ch2_mode <= new_mode;
        end
    end

    // ------------------------------------------------------------
    // command, request, mask and status
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            disabled <= 1'b0;
            sw_req   <= '0;
            mask     <= MASK_RESET;
            term     <= '0;
        end else if (clear) begin
            disabled <= 1'b0;
            sw_req   <= '0;
            mask     <= MASK_RESET;
            term     <= '0;
        end else begin
            if (wr_stb && io.address == REG_STATUS_CMD)
                disabled <= io.writedata[2];    // controller disable
            if (wr_stb && io.address == REG_REQUEST)
                sw_req <= cmd.flag.set ? (sw_req | cmd_bit) : (sw_req & ~cmd_bit);
            if (wr_stb && io.address == REG_CLEAR_MASK)
                mask <= '0;
            else if (wr_stb && io.address == REG_ALL_MASK)
                mask <= io.writedata[3:0];
            else if (wr_stb && io.address == REG_SINGLE_MASK)
                mask <= cmd.flag.set ? (mask | cmd_bit) : (mask & ~cmd_bit);
            else
                mask <= mask | (tc_bits & ~auto_bits);  // single-shot channels mask themselves
            // a status read clears the terminal bits, a new tc still lands
            term <= ((rd_stb && io.address == REG_STATUS_CMD) ? 4'h0 : term) | tc_bits;
        end
    end

    assign pending = sw_req | {1'b0, flp_level, snd_level, 1'b0};

    // fixed priority, channel 1 first
    assign en1        = !disabled && pending[1] && !mask[1];
    assign en2        = !disabled && pending[2] && !mask[2];
    assign ch1_grant  = en1;
    assign ch2_grant  = en2 && !en1;
    assign ch1_resume = !disabled && !mask[1];
    assign ch2_resume = !disabled && !mask[2] && !en1;

    function automatic byte_t pick(word_t w, logic hi);
        return hi ? w[15:8] : w[7:0];
    endfunction

    always_comb begin
        case (io.address)
            REG_ADDR_CH1:   readback = pick(ch1_addr, ptr);
            REG_COUNT_CH1:  readback = pick(ch1_count, ptr);
            REG_ADDR_CH2:   readback = pick(ch2_addr, ptr);
            REG_COUNT_CH2:  readback = pick(ch2_count, ptr);
            REG_STATUS_CMD: readback = {pending, term};
            REG_ALL_MASK:   readback = {4'hf, mask};
            default:        readback = '0;
        endcase
    end

endmodule

// File: source/dma_page_regs.sv
`timescale 1ns/1ps

module dma_page_regs
    import dma_reg_pkg::*, dma_xfer_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  io_bus_t io,
    output byte_t   readback,
    output byte_t   page_ch1,
    output byte_t   page_ch2
);

    byte_t scratch;     // answers every other page offset
    logic  wr_stb;

    assign wr_stb = io.write && io.page_cs;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            page_ch1 <= '0;
            page_ch2 <= '0;
            scratch  <= '0;
        end else if (wr_stb) begin
            case (io.address)
                PAGE_CH1: page_ch1 <= io.writedata;
                PAGE_CH2: page_ch2 <= io.writedata;
                default:  scratch  <= io.writedata;
            endcase
        end
    end

    always_comb begin
        case (io.address)
            PAGE_CH1: readback = page_ch1;
            PAGE_CH2: readback = page_ch2;
            default:  readback = scratch;
        endcase
    end

endmodule

// File: source/dma_reg_pkg.sv
package dma_reg_pkg;

    // ------------------------------------------------------------
    // slave controller register offsets
    // ------------------------------------------------------------
    localparam logic [3:0] REG_ADDR_CH1     = 4'd2;
    localparam logic [3:0] REG_COUNT_CH1    = 4'd3;
    localparam logic [3:0] REG_ADDR_CH2     = 4'd4;
    localparam logic [3:0] REG_COUNT_CH2    = 4'd5;
    localparam logic [3:0] REG_STATUS_CMD   = 4'd8;
    localparam logic [3:0] REG_REQUEST      = 4'd9;
    localparam logic [3:0] REG_SINGLE_MASK  = 4'd10;
    localparam logic [3:0] REG_MODE         = 4'd11;
    localparam logic [3:0] REG_CLEAR_PTR    = 4'd12;
    localparam logic [3:0] REG_MASTER_RESET = 4'd13;
    localparam logic [3:0] REG_CLEAR_MASK   = 4'd14;
    localparam logic [3:0] REG_ALL_MASK     = 4'd15;

    // page register offsets
    localparam logic [3:0] PAGE_CH1 = 4'd3;
    localparam logic [3:0] PAGE_CH2 = 4'd1;

    localparam logic [1:0] XFER_VERIFY = 2'd0;
    localparam logic [1:0] XFER_WRITE  = 2'd1;  // device to memory
    localparam logic [1:0] XFER_READ   = 2'd2;  // memory to device

    localparam logic [3:0] MASK_RESET = 4'hf;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;

    typedef struct packed {
        logic [1:0] transfer;
        logic       auto_init;
        logic       decrement;
    } chan_mode_t;

    // ------------------------------------------------------------
    // command byte, as written to the mode or a flag register
    // ------------------------------------------------------------
    typedef struct packed {
        logic [1:0] select;     // demand/single/block, not modelled
        logic       decrement;
        logic       auto_init;
        logic [1:0] transfer;
        logic [1:0] channel;
    } mode_cmd_t;

    typedef struct packed {
        logic [4:0] unused;
        logic       set;
        logic [1:0] channel;
    } flag_cmd_t;

    typedef union packed {
        mode_cmd_t mode;
        flag_cmd_t flag;
    } dma_cmd_u;

    typedef struct packed {
        logic  addr_we;
        logic  count_we;
        logic  high_byte;
        byte_t data;
    } chan_wr_t;

endpackage

// File: source/dma_top.sv
`timescale 1ns/1ps

module dma_top
    import dma_reg_pkg::*, dma_xfer_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  io_bus_t  io,
    output byte_t    io_readdata,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp,
    input  dev_req_t snd_req,
    input  dev_req_t flp_req,
    output dev_rsp_t snd_rsp,
    output dev_rsp_t flp_rsp
);

    chan_wr_t   ch1_wr, ch2_wr;
    word_t      ch1_addr, ch1_count, ch2_addr, ch2_count;
    chan_mode_t ch1_mode, ch2_mode;
    logic       ch1_grant, ch2_grant, ch1_resume, ch2_resume, clear;
    logic       ch1_busy, ch2_busy, ch1_update, ch2_update, ch1_tc, ch2_tc;
    logic       ch1_issue_read, ch1_issue_write, ch2_issue_read, ch2_issue_write;
    logic       ch1_done, ch2_done, ch1_ack, ch2_ack, ch1_term, ch2_term;
    byte_t      ctrl_rb, page_rb, page_ch1, page_ch2, xfer_data;

    always_ff @(posedge clk) begin
        if (io.read)
            io_readdata <= io.page_cs ? page_rb : ctrl_rb;
    end

    assign snd_rsp = '{ack: ch1_ack, terminal: ch1_term, readdata: xfer_data};
    assign flp_rsp = '{ack: ch2_ack, terminal: ch2_term, readdata: xfer_data};

    dma_control_regs u_ctrl (
        .clk, .rst_n, .io, .readback(ctrl_rb), .ch1_wr, .ch2_wr,
        .ch1_addr, .ch1_count, .ch2_addr, .ch2_count, .ch1_mode, .ch2_mode,
        .ch1_grant, .ch2_grant, .ch1_resume, .ch2_resume, .clear,
        .snd_level(snd_req.req || ch1_busy), .flp_level(flp_req.req || ch2_busy),
        .ch1_tc, .ch2_tc
    );

    dma_channel_regs u_ch1_regs (
        .clk, .rst_n, .wr(ch1_wr), .mode(ch1_mode), .update(ch1_update), .tc(ch1_tc),
        .clear, .cur_addr(ch1_addr), .cur_count(ch1_count)
    );

    dma_channel_regs u_ch2_regs (
        .clk, .rst_n, .wr(ch2_wr), .mode(ch2_mode), .update(ch2_update), .tc(ch2_tc),
        .clear, .cur_addr(ch2_addr), .cur_count(ch2_count)
    );

    dma_page_regs u_page (.clk, .rst_n, .io, .readback(page_rb), .page_ch1, .page_ch2);

    // channel 1 wins ties but never cuts into a channel 2 beat
    dma_channel_fsm u_ch1_fsm (
        .clk, .rst_n, .clear, .grant(ch1_grant && !ch2_busy),
        .resume(ch1_resume && !ch2_busy), .mode(ch1_mode), .dev(snd_req),
        .beat_done(ch1_done), .count_zero(ch1_count == 16'd0),
        .issue_read(ch1_issue_read), .issue_write(ch1_issue_write), .busy(ch1_busy),
        .update(ch1_update), .tc(ch1_tc), .ack(ch1_ack), .terminal(ch1_term)
    );

    dma_channel_fsm u_ch2_fsm (
        .clk, .rst_n, .clear, .grant(ch2_grant), .resume(ch2_resume), .mode(ch2_mode),
        .dev(flp_req), .beat_done(ch2_done), .count_zero(ch2_count == 16'd0),
        .issue_read(ch2_issue_read), .issue_write(ch2_issue_write), .busy(ch2_busy),
        .update(ch2_update), .tc(ch2_tc), .ack(ch2_ack), .terminal(ch2_term)
    );

    dma_bus_master u_bus (
        .clk, .rst_n, .ch1_issue_read, .ch1_issue_write, .ch2_issue_read, .ch2_issue_write,
        .ch1_address({page_ch1, ch1_addr}), .ch2_address({page_ch2, ch2_addr}),
        .ch1_data(snd_req.writedata), .ch2_data(flp_req.writedata),
        .mem_req, .mem_rsp, .ch1_done, .ch2_done, .readdata(xfer_data)
    );

endmodule

// File: source/dma_xfer_pkg.sv
package dma_xfer_pkg;

    typedef enum logic [2:0] {
        IDLE,
        PREPARE,
        BUS,
        VERIFY,
        UPDATE,
        HOLD
    } xfer_state_e;

    typedef struct packed {
        logic [23:0] address;   // page byte over current address
        logic        read;
        logic        write;
        logic [7:0]  writedata;
    } mem_req_t;

    typedef struct packed {
        logic       waitrequest;
        logic       readdatavalid;
        logic [7:0] readdata;
    } mem_rsp_t;

    typedef struct packed {
        logic       req;
        logic [7:0] writedata;
    } dev_req_t;

    typedef struct packed {
        logic       ack;
        logic       terminal;
        logic [7:0] readdata;
    } dev_rsp_t;

    typedef struct packed {
        logic [3:0] address;
        logic       read;
        logic       write;
        logic [7:0] writedata;
        logic       slave_cs;
        logic       page_cs;
    } io_bus_t;

endpackage

// File: tb.f
source/dma_reg_pkg.sv
source/dma_xfer_pkg.sv
source/dma_control_regs.sv
source/dma_channel_regs.sv
source/dma_page_regs.sv
source/dma_channel_fsm.sv
source/dma_bus_master.sv
source/dma_top.sv
dv/dma_props.sv
dv/dma_tb.sv
